// File: analog_frontend_top.f
source/rp_pkg.sv
source/linear_cal.sv
source/debounce_timer.sv
source/debounce_fsm.sv
source/pdm_dac.sv
source/analog_frontend_top.sv
verif/tb_analog_frontend.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the analog front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_analog_frontend
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" \
  -f analog_frontend_top.f --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

// File: source/analog_frontend_top.sv
// analog front end, top level
// ADC capture with sign conversion, optional digital loopback,
// gain/offset calibration in both directions, DAC code formatting,
// auxiliary PDM outputs and a debounced trigger from expansion pin 0

`timescale 1ns/1ns

module analog_frontend_top import rp_pkg::*; #(
  parameter int unsigned MNA     = 2,
  parameter int unsigned PDM_CHN = 4,
  parameter int unsigned DEB_CW  = 20,
  parameter int unsigned DEB_LEN = 62500
) (
  input  logic                           adc_clk,
  input  logic                           top_rst,
  // ADC, sample in bits 15..2
  input  logic     [MNA-1:0][16-1:0]     adc_dat_i,
  // samples to generate
  input  smp_t     [MNA-1:0]             gen_dat_i,
  input  logic                           digital_loop_i,
  // calibration
  input  cal_mul_t [MNA-1:0]             adc_cfg_mul_i,
  input  cal_sum_t [MNA-1:0]             adc_cfg_sum_i,
  input  cal_mul_t [MNA-1:0]             dac_cfg_mul_i,
  input  cal_sum_t [MNA-1:0]             dac_cfg_sum_i,
  // PDM densities
  input  pdm_t     [PDM_CHN-1:0]         pdm_cfg_i,
  // expansion pin 0
  input  logic                           exp_i,
  // calibrated ADC stream
  output smp_t     [MNA-1:0]             osc_dat_o,
  // DAC codes, one port per channel
  output logic     [MNA-1:0][SMP_W-1:0]  dac_dat_o,
  output logic     [PDM_CHN-1:0]         dac_pwm_o,
  output logic                           trg_pos_o,
  output logic                           trg_neg_o
);

  //////////////////////////////////////////////////////////////////////
  // ADC and DAC channels
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MNA; i++) begin : g_ch

    smp_t adc_raw_q;
    smp_t adc_cal_in;
    smp_t dac_cal;

    // offset binary to two's complement, inverted slope
    // low two bits unused by the 14-bit converter
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        adc_raw_q <= '0;
      end else begin
        adc_raw_q <= {adc_dat_i[i][15], ~adc_dat_i[i][14:2]};
      end
    end

    // loopback takes calibrated DAC data before formatting
    assign adc_cal_in = digital_loop_i ? dac_cal : adc_raw_q;

    linear_cal #(
      .SMP_T (smp_t)
    ) linear_adc (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .sti_dat_i (adc_cal_in),
      .cfg_mul_i (adc_cfg_mul_i[i]),
      .cfg_sum_i (adc_cfg_sum_i[i]),
      .sto_dat_o (osc_dat_o[i])
    );

    linear_cal #(
      .SMP_T (smp_t)
    ) linear_dac (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .sti_dat_i (gen_dat_i[i]),
      .cfg_mul_i (dac_cfg_mul_i[i]),
      .cfg_sum_i (dac_cfg_sum_i[i]),
      .sto_dat_o (dac_cal)
    );

    // signed to DAC code, negative slope
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        dac_dat_o[i] <= '0;
      end else begin
        dac_dat_o[i] <= {dac_cal[SMP_W-1], ~dac_cal[SMP_W-2:0]};
      end
    end

  end : g_ch

  //////////////////////////////////////////////////////////////////////
  // auxiliary outputs and trigger
  //////////////////////////////////////////////////////////////////////

  pdm_dac #(
    .PDM_CHN (PDM_CHN)
  ) pdm (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .pdm_cfg_i (pdm_cfg_i),
    .pdm_o     (dac_pwm_o)
  );

  // default settle is 0.5 ms at 125 MHz
  debounce_fsm #(
    .DEB_CW  (DEB_CW),
    .DEB_LEN (DEB_LEN)
  ) debounce (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .d_i       (exp_i),
    .trg_pos_o (trg_pos_o),
    .trg_neg_o (trg_neg_o)
  );

endmodule : analog_frontend_top

// File: source/debounce_fsm.sv
// edge trigger debouncer
// two-flop synchronizer followed by a stable/settling state machine
// a level change is accepted only after it holds for the settle time
// the accepted edge is reported as a one-cycle pulse

`timescale 1ns/1ns

module debounce_fsm #(
  parameter int unsigned DEB_CW  = 20,
  parameter int unsigned DEB_LEN = 62500
) (
  input  logic adc_clk,
  input  logic top_rst,
  input  logic d_i,
  output logic trg_pos_o,
  output logic trg_neg_o
);

  typedef enum logic {
    ST_STABLE,
    ST_SETTLE
  } deb_state_t;

  deb_state_t  state_q;
  logic [1:0]  sync_q;
  logic        din;
  logic        lvl_q;
  logic        load;
  logic        stop;
  logic        done;
  logic        flip;

  //////////////////////////////////////////////////////////////////////
  // synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], d_i};
    end
  end

  assign din = sync_q[1];

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  // start timing on a change, drop it on a bounce back
  assign load = (state_q == ST_STABLE) && (din != lvl_q);
  assign stop = (state_q == ST_SETTLE) && (din == lvl_q);
  // held through the whole interval
  assign flip = (state_q == ST_SETTLE) && (din != lvl_q) && done;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q   <= ST_STABLE;
      lvl_q     <= 1'b0;
      trg_pos_o <= 1'b0;
      trg_neg_o <= 1'b0;
    end else begin
      // edge pulses, direction from the old level
      trg_pos_o <= flip && !lvl_q;
      trg_neg_o <= flip && lvl_q;
      if (flip) begin
        lvl_q <= ~lvl_q;
      end
      case (state_q)
        ST_STABLE: if (load) state_q <= ST_SETTLE;
        ST_SETTLE: if (stop || flip) state_q <= ST_STABLE;
        default:   state_q <= ST_STABLE;
      endcase
    end
  end

  debounce_timer #(
    .DEB_CW (DEB_CW)
  ) timer (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .load_i  (load),
    .stop_i  (stop),
    .len_i   (DEB_CW'(DEB_LEN)),
    .done_o  (done)
  );

endmodule : debounce_fsm

// File: source/debounce_timer.sv
// debounce settle timer
// loadable down-counter, done pulses for one cycle on the last count

`timescale 1ns/1ns

module debounce_timer #(
  parameter int unsigned DEB_CW = 20
) (
  input  logic              adc_clk,
  input  logic              top_rst,
  input  logic              load_i,
  input  logic              stop_i,
  input  logic [DEB_CW-1:0] len_i,
  output logic              done_o
);

  // zero means idle
  logic [DEB_CW-1:0] cnt_q;

  // load wins over stop, counting only while nonzero
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= len_i;
    end else if (stop_i) begin
      cnt_q <= '0;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // last count of a running interval
  assign done_o = (cnt_q == DEB_CW'(1));

endmodule : debounce_timer

// File: source/linear_cal.sv
// linear calibration stage
// multiplies a sample by a gain, scales the product back, adds an
// offset and saturates to the payload range
// two pipeline stages, one sample accepted per clock

`timescale 1ns/1ns

module linear_cal import rp_pkg::*; #(
  parameter type SMP_T = smp_t
) (
  input  logic     adc_clk,
  input  logic     top_rst,
  input  SMP_T     sti_dat_i,
  input  cal_mul_t cfg_mul_i,
  input  cal_sum_t cfg_sum_i,
  output SMP_T     sto_dat_o
);

  // payload, product and sum widths
  localparam int DW = $bits(SMP_T);
  localparam int PW = DW + CAL_MUL_W;
  localparam int SW = PW + 1;

  // saturation limits in sum width
  localparam logic signed [SW-1:0] SAT_MAX = SW'(2 ** (DW - 1) - 1);
  localparam logic signed [SW-1:0] SAT_MIN = SW'(-(2 ** (DW - 1)));

  logic signed [PW-1:0] mul_q;
  cal_sum_t             sum_q;
  logic signed [SW-1:0] shf;
  logic signed [SW-1:0] sum;
  logic        [DW-1:0] sat;

  // stage 1, product register
  // offset travels with its sample
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      mul_q <= '0;
      sum_q <= '0;
    end else begin
      mul_q <= $signed(sti_dat_i) * cfg_mul_i;
      sum_q <= cfg_sum_i;
    end
  end

  // arithmetic shift keeps the sign
  assign shf = mul_q >>> CAL_SHIFT;
  assign sum = shf + sum_q;

  // clamp to payload range
  always_comb begin
    if (sum > SAT_MAX) begin
      sat = SAT_MAX[DW-1:0];
    end else if (sum < SAT_MIN) begin
      sat = SAT_MIN[DW-1:0];
    end else begin
      sat = sum[DW-1:0];
    end
  end

  // stage 2, sum and saturate register
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sto_dat_o <= '0;
    end else begin
      sto_dat_o <= sat;
    end
  end

endmodule : linear_cal

// File: source/pdm_dac.sv
// pulse density modulators for the auxiliary analog outputs
// first order, one accumulator per channel, modulus PDM_RNG
// output density equals setting / PDM_RNG

`timescale 1ns/1ns

module pdm_dac import rp_pkg::*; #(
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  pdm_t       [PDM_CHN-1:0] pdm_cfg_i,
  output logic       [PDM_CHN-1:0] pdm_o
);

  // modulus in sum width
  localparam logic [PDM_W:0] RNG = (PDM_W + 1)'(PDM_RNG);

  for (genvar i = 0; i < PDM_CHN; i++) begin : g_chn

    // accumulator stays below RNG
    logic [PDM_W-1:0] acc_q;
    // one extra bit for the carry
    logic [PDM_W:0]   sum;

    assign sum = acc_q + pdm_cfg_i[i];

    // wrap and emit a one on overflow
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc_q    <= '0;
        pdm_o[i] <= 1'b0;
      end else if (sum >= RNG) begin
        acc_q    <= PDM_W'(sum - RNG);
        pdm_o[i] <= 1'b1;
      end else begin
        acc_q    <= sum[PDM_W-1:0];
        pdm_o[i] <= 1'b0;
      end
    end

  end : g_chn

endmodule : pdm_dac

// File: source/rp_pkg.sv
// shared definitions for the analog front end
// sample, calibration and PDM types plus their widths
// used by the calibration, PDM and top-level blocks

package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and constants
  //////////////////////////////////////////////////////////////////////

  // ADC and DAC sample width
  localparam int unsigned SMP_W = 14;

  // calibration gain width, unity gain is 1 << CAL_SHIFT
  localparam int unsigned CAL_MUL_W = 16;

  // product scaling back to sample range
  localparam int unsigned CAL_SHIFT = 14;

  // PDM density width and modulus
  localparam int unsigned PDM_W = 8;
  localparam int unsigned PDM_RNG = 255;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // signed sample on ADC and DAC streams
  typedef logic signed [SMP_W-1:0] smp_t;

  // calibration gain, 16384 is 1.0
  typedef logic signed [CAL_MUL_W-1:0] cal_mul_t;

  // calibration offset, same range as a sample
  typedef logic signed [SMP_W-1:0] cal_sum_t;

  // PDM density setting
  typedef logic [PDM_W-1:0] pdm_t;

endpackage : rp_pkg

// File: verif/analog_frontend_vectors.txt
// columns: mode sample gain offset expected, all hex, one row per line
// mode 1 drives adc_dat_i, mode 2 drives gen_dat_i, mode f ends the table
1 0000 4000 0000 1fff
1 fffc 4000 0000 2000
1 8000 4000 0000 3fff
1 7ffc 4000 0064 0064
1 8000 2000 0005 0004
1 4000 c000 0010 3011
1 0000 4000 0100 1fff
1 fffc 7fff 3fff 2000
1 fffc 4000 3f00 2000
2 0000 4000 0000 1fff
2 1fff 4000 0000 0000
2 2000 4000 0000 3fff
2 1000 6000 0000 07ff
2 1000 7fff 0010 0000
2 3000 7fff 3ff0 3fff
2 3ffe e000 3ffd 2001
f 0000 0000 0000 0000

// File: verif/tb_analog_frontend.sv
// testbench for the analog front end
// calibration rows from a vector file, random loopback stream,
// PDM density counts, debounce glitch rejection and reset values

`timescale 1ns/1ns

module tb_analog_frontend import rp_pkg::*; ();

  localparam int MNA      = 2;
  localparam int PDM_CHN  = 4;
  localparam int DEB_LEN  = 16;
  localparam int CLK_HALF = 10;
  localparam int RST_CYC  = 8;
  localparam int VEC_MAX  = 32;
  localparam int LOOP_N   = 64;
  localparam int PDM_WIN  = 255;
  localparam int GLITCH_N = 16;
  localparam int GAP_CYC  = 6;
  localparam int HOLD_CYC = 40;
  // rough length of all phases, then doubled with margin
  localparam int RUN_CYC = RST_CYC + 4 + VEC_MAX * 5 + LOOP_N + 6
                         + PDM_CHN * (PDM_WIN + 3) + GLITCH_N * (8 + GAP_CYC)
                         + DEB_LEN + 4 + 2 * HOLD_CYC;
  localparam int TIMEOUT_CYC = 2 * RUN_CYC + 400;

  // loopback calibration per channel
  localparam cal_mul_t [1:0] LB_DAC_MUL = {16'hC000, 16'h5000};
  localparam cal_sum_t [1:0] LB_DAC_SUM = {14'h0003, 14'h0020};
  localparam cal_mul_t [1:0] LB_ADC_MUL = {16'h4000, 16'h3800};
  localparam cal_sum_t [1:0] LB_ADC_SUM = {14'h0000, 14'h3FF0};
  // PDM densities, rotated over the channels
  localparam pdm_t [3:0] PDM_SET = {8'd255, 8'd100, 8'd1, 8'd0};

  logic                      adc_clk;
  logic                      top_rst;
  logic [MNA-1:0][15:0]      adc_dat;
  smp_t [MNA-1:0]            gen_dat;
  logic                      digital_loop;
  cal_mul_t [MNA-1:0]        adc_mul;
  cal_sum_t [MNA-1:0]        adc_sum;
  cal_mul_t [MNA-1:0]        dac_mul;
  cal_sum_t [MNA-1:0]        dac_sum;
  pdm_t [PDM_CHN-1:0]        pdm_cfg;
  logic                      exp_pin;
  smp_t [MNA-1:0]            osc_dat;
  logic [MNA-1:0][SMP_W-1:0] dac_dat;
  logic [PDM_CHN-1:0]        dac_pwm;
  logic                      trg_pos;
  logic                      trg_neg;

  // five words per row
  logic [15:0] vec_mem [VEC_MAX*5];
  smp_t        lb_hist [LOOP_N][MNA];
  logic [15:0] lfsr_q;
  int          cyc_cnt = 0;
  int          pos_cnt = 0;
  int          neg_cnt = 0;

  analog_frontend_top #(
    .MNA     (MNA),
    .PDM_CHN (PDM_CHN),
    .DEB_CW  (20),
    .DEB_LEN (DEB_LEN)
  ) UUT (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat),
    .gen_dat_i      (gen_dat),
    .digital_loop_i (digital_loop),
    .adc_cfg_mul_i  (adc_mul),
    .adc_cfg_sum_i  (adc_sum),
    .dac_cfg_mul_i  (dac_mul),
    .dac_cfg_sum_i  (dac_sum),
    .pdm_cfg_i      (pdm_cfg),
    .exp_i          (exp_pin),
    .osc_dat_o      (osc_dat),
    .dac_dat_o      (dac_dat),
    .dac_pwm_o      (dac_pwm),
    .trg_pos_o      (trg_pos),
    .trg_neg_o      (trg_neg)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model and helpers
  //////////////////////////////////////////////////////////////////////

  // offset binary with inverted slope to two's complement
  function automatic logic [13:0] capture_ref(input logic [15:0] a);
    return {a[15], ~a[14:2]};
  endfunction

  // gain, arithmetic shift, offset, clamp
  function automatic logic [13:0] cal_ref(input logic [13:0] x, input logic [15:0] g,
                                          input logic [13:0] o);
    longint p;
    longint s;
    p = longint'($signed(x)) * longint'($signed(g));
    s = (p >>> CAL_SHIFT) + longint'($signed(o));
    if (s > 2 ** (SMP_W - 1) - 1) begin
      s = 2 ** (SMP_W - 1) - 1;
    end else if (s < -(2 ** (SMP_W - 1))) begin
      s = -(2 ** (SMP_W - 1));
    end
    return s[13:0];
  endfunction

  // sign kept, magnitude bits inverted
  function automatic logic [13:0] dac_code_ref(input logic [13:0] v);
    return {v[13], ~v[12:0]};
  endfunction

  // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // one step per bit
  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      val    = {val[14:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_idle(input string when_s);
    check_eq($sformatf("%s trg_pos_o", when_s), trg_pos, 0);
    check_eq($sformatf("%s trg_neg_o", when_s), trg_neg, 0);
    check_eq($sformatf("%s dac_pwm_o", when_s), dac_pwm, 0);
    for (int ch = 0; ch < MNA; ch++) begin
      check_eq($sformatf("%s osc_dat_o[%0d]", when_s, ch), $unsigned(osc_dat[ch]), 0);
      check_eq($sformatf("%s dac_dat_o[%0d]", when_s, ch), dac_dat[ch], 0);
    end
  endtask

  // one calibration row on both channels
  task automatic run_vector_row(input int row);
    logic [15:0] mode;
    logic [15:0] smp;
    logic [15:0] gain;
    logic [15:0] offs;
    logic [15:0] expv;
    logic [15:0] refv;
    mode = vec_mem[row*5];
    smp  = vec_mem[row*5+1];
    gain = vec_mem[row*5+2];
    offs = vec_mem[row*5+3];
    expv = vec_mem[row*5+4];
    @(posedge adc_clk);
    for (int ch = 0; ch < MNA; ch++) begin
      if (mode == 16'h0001) begin
        adc_dat[ch] <= smp;
        adc_mul[ch] <= gain;
        adc_sum[ch] <= offs[SMP_W-1:0];
      end else begin
        gen_dat[ch] <= smp[SMP_W-1:0];
        dac_mul[ch] <= gain;
        dac_sum[ch] <= offs[SMP_W-1:0];
      end
    end
    if (mode == 16'h0001) begin
      refv = cal_ref(capture_ref(smp), gain, offs[13:0]);
    end else begin
      refv = dac_code_ref(cal_ref(smp[13:0], gain, offs[13:0]));
    end
    check_eq($sformatf("row %0d file value", row), expv, refv);
    // fixed three-cycle path
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    for (int ch = 0; ch < MNA; ch++) begin
      if (mode == 16'h0001) begin
        check_eq($sformatf("row %0d osc_dat_o[%0d]", row, ch), $unsigned(osc_dat[ch]), expv);
      end else begin
        check_eq($sformatf("row %0d dac_dat_o[%0d]", row, ch), dac_dat[ch], expv);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // clock, watchdog and trigger counters
  //////////////////////////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #CLK_HALF adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt > TIMEOUT_CYC) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      fail_run();
    end
  end

  always @(negedge adc_clk) begin
    if (trg_pos) pos_cnt <= pos_cnt + 1;
    if (trg_neg) neg_cnt <= neg_cnt + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          row;
    int          glen;
    int          ones [PDM_CHN];
    logic [15:0] rnd;
    top_rst      = 1'b1;
    adc_dat      = '0;
    gen_dat      = '0;
    digital_loop = 1'b0;
    adc_mul      = '0;
    adc_sum      = '0;
    dac_mul      = '0;
    dac_sum      = '0;
    pdm_cfg      = '0;
    exp_pin      = 1'b0;
    lfsr_q       = 16'd46065;
    $readmemh("verif/analog_frontend_vectors.txt", vec_mem);

    // outputs held at zero through reset
    for (int c = 0; c < RST_CYC; c++) begin
      @(negedge adc_clk);
      check_idle("in reset");
    end
    @(posedge adc_clk);
    top_rst <= 1'b0;
    @(negedge adc_clk);
    check_idle("after reset");
    // code of a zero sample once the DAC path has run
    repeat (3) @(posedge adc_clk);
    @(negedge adc_clk);
    for (int ch = 0; ch < MNA; ch++) begin
      check_eq($sformatf("zero code dac_dat_o[%0d]", ch), dac_dat[ch],
               dac_code_ref(cal_ref(14'h0, 16'h0, 14'h0)));
    end

    // calibration rows until the end marker
    row = 0;
    while (vec_mem[row*5] !== 16'h000F) begin
      if ((vec_mem[row*5] !== 16'h0001 && vec_mem[row*5] !== 16'h0002)
          || row >= VEC_MAX - 1) begin
        $display("vector table row %0d has a bad mode or the end row is missing", row);
        fail_run();
      end
      run_vector_row(row);
      row++;
    end

    // loopback stream, checked every cycle
    @(posedge adc_clk);
    digital_loop <= 1'b1;
    dac_mul      <= LB_DAC_MUL;
    dac_sum      <= LB_DAC_SUM;
    adc_mul      <= LB_ADC_MUL;
    adc_sum      <= LB_ADC_SUM;
    for (int n = 0; n < LOOP_N + 4; n++) begin
      @(posedge adc_clk);
      if (n < LOOP_N) begin
        for (int ch = 0; ch < MNA; ch++) begin
          take_bits(SMP_W, rnd);
          lb_hist[n][ch] = rnd[SMP_W-1:0];
          gen_dat[ch]   <= rnd[SMP_W-1:0];
        end
      end
      @(negedge adc_clk);
      if (n >= 4) begin
        for (int ch = 0; ch < MNA; ch++) begin
          check_eq($sformatf("loopback %0d osc_dat_o[%0d]", n - 4, ch), $unsigned(osc_dat[ch]),
                   cal_ref(cal_ref(lb_hist[n-4][ch], LB_DAC_MUL[ch], LB_DAC_SUM[ch]),
                           LB_ADC_MUL[ch], LB_ADC_SUM[ch]));
        end
      end
    end
    @(posedge adc_clk);
    digital_loop <= 1'b0;

    // PDM densities, each setting on each output
    for (int r = 0; r < PDM_CHN; r++) begin
      @(posedge adc_clk);
      for (int p = 0; p < PDM_CHN; p++) begin
        pdm_cfg[p] <= PDM_SET[(p + r) % PDM_CHN];
        ones[p]     = 0;
      end
      repeat (2) @(posedge adc_clk);
      for (int w = 0; w < PDM_WIN; w++) begin
        @(negedge adc_clk);
        for (int p = 0; p < PDM_CHN; p++) begin
          ones[p] += int'(dac_pwm[p]);
        end
      end
      for (int p = 0; p < PDM_CHN; p++) begin
        check_eq($sformatf("ones on dac_pwm_o[%0d]", p), ones[p], PDM_SET[(p + r) % PDM_CHN]);
      end
    end

    // short glitches never trigger
    for (int g = 0; g < GLITCH_N; g++) begin
      take_bits(3, rnd);
      glen = (rnd[2:0] == 3'd0) ? 1 : int'(rnd[2:0]);
      @(posedge adc_clk);
      exp_pin <= 1'b1;
      repeat (glen) @(posedge adc_clk);
      exp_pin <= 1'b0;
      repeat (GAP_CYC) @(posedge adc_clk);
    end
    repeat (DEB_LEN + 4) @(posedge adc_clk);
    check_eq("trg_pos_o pulses after glitches", pos_cnt, 0);
    check_eq("trg_neg_o pulses after glitches", neg_cnt, 0);

    // held rising level, then held falling level
    @(posedge adc_clk);
    exp_pin <= 1'b1;
    repeat (HOLD_CYC) @(posedge adc_clk);
    check_eq("trg_pos_o pulses after rise", pos_cnt, 1);
    check_eq("trg_neg_o pulses after rise", neg_cnt, 0);
    exp_pin <= 1'b0;
    repeat (HOLD_CYC) @(posedge adc_clk);
    check_eq("trg_pos_o pulses after fall", pos_cnt, 1);
    check_eq("trg_neg_o pulses after fall", neg_cnt, 1);

    $display("TEST OK");
    $finish;
  end

endmodule : tb_analog_frontend
